/* bench/tb_calendar_clock.sv */
`default_nettype none

module tb_calendar_clock;

    import clock_pkg::*;

    localparam int debounce_cycles = 20;
    localparam int hold_cycles     = 25;    // qualifies a press with some margin
    // about 245 presses in tests 1 and 2, 110 in test 3 and 190 in test 5
    localparam int press_budget    = 600;
    // at most 77 ticks in test 4 and 14 in test 5
    localparam int tick_budget     = 100;
    localparam int cycle_limit     = press_budget * 30 + tick_budget * 4 + 500;

    logic       clk_in;
    logic       rst;
    logic [2:0] sw;
    logic [1:0] key;
    logic       tick_1hz;
    digit_t     digit1, digit2, digit3, digit4;
    digit_t     digit5, digit6, digit7, digit8;

    int         errors;
    int         checks;
    int         cycle_count;
    logic [7:0] lfsr_state;

    // expected editor state
    logic [2:0] cur_mode;
    int         cur_field;
    digit_t     yd [0:3];       // year digits, thousands first
    month_t     mon_m;
    day_t       day_m;
    hour_t      hour_m;
    minsec_t    min_m;
    minsec_t    sec_m;

    // expected running clock
    year_t      run_y;
    month_t     run_mo;
    day_t       run_d;
    hour_t      run_h;
    minsec_t    run_mi;
    minsec_t    run_s;

    calendar_clock_top #(.debounce_cycles(debounce_cycles)) dut0 (
        .clk_in(clk_in), .rst(rst), .sw(sw), .key(key), .tick_1hz(tick_1hz),
        .digit1(digit1), .digit2(digit2), .digit3(digit3), .digit4(digit4),
        .digit5(digit5), .digit6(digit6), .digit7(digit7), .digit8(digit8)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int random_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    function automatic int month_days(int y, int m);
        bit leap;
        leap = ((y % 4 == 0) && (y % 100 != 0)) || (y % 400 == 0);
        case (m)
            2:          return leap ? 29 : 28;
            4, 6, 9, 11: return 30;
            default:    return 31;
        endcase
    endfunction

    function automatic year_t set_year();
        int v;
        v = yd[0] * 1000 + yd[1] * 100 + yd[2] * 10 + yd[3];
        return (v == 0) ? 14'd1 : year_t'(v);
    endfunction

    // expected running time and date after n counting ticks
    function automatic void advance_clock(input int n, input bit date_on,
                                          inout year_t y, inout month_t mo, inout day_t d,
                                          inout hour_t h, inout minsec_t mi, inout minsec_t s);
        int total;
        int days;
        total = h * 3600 + mi * 60 + s + n;
        days  = total / 86400;
        total = total % 86400;
        h  = hour_t'(total / 3600);
        mi = minsec_t'((total / 60) % 60);
        s  = minsec_t'(total % 60);
        if (date_on) begin
            repeat (days) begin
                if (d >= month_days(y, mo)) begin
                    d = 1;
                    mo = (mo == 12) ? 4'd1 : mo + 4'd1;
                    if (mo == 1) y = y + 1;     // new year
                end else begin
                    d = d + 1;
                end
            end
        end
    endfunction

    // one increment on the field under the cursor
    function automatic void model_inc();
        if (cur_mode == 3'b001) begin
            case (cur_field)
                0, 1, 2, 3: yd[cur_field] = digit_t'((yd[cur_field] + 1) % 10);
                4:          mon_m = month_t'((mon_m % 12) + 1);
                5:          day_m = (day_m >= month_days(set_year(), mon_m)) ? 5'd1 : day_m + 5'd1;
                default:    ;
            endcase
        end else if (cur_mode == 3'b011) begin
            case (cur_field)
                0:       hour_m = hour_t'((hour_m + 1) % 24);
                1:       min_m = minsec_t'((min_m + 1) % 60);
                2:       sec_m = minsec_t'((sec_m + 1) % 60);
                default: ;
            endcase
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic settle();
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);      // sample away from the active edge
    endtask

    task automatic do_reset();
        @(posedge clk_in);
        rst <= 1'b0;
        sw  <= 3'b000;
        repeat (16) @(posedge clk_in);
        rst <= 1'b1;
        cur_mode  = 3'b000;
        cur_field = 0;
        yd = '{4'd0, 4'd0, 4'd0, 4'd1};
        mon_m  = 1;
        day_m  = 1;
        hour_m = 0;
        min_m  = 0;
        sec_m  = 0;
        settle();
    endtask

    task automatic press_key(input int idx, input int hold);
        @(posedge clk_in);
        key[idx] <= 1'b0;
        repeat (hold) @(posedge clk_in);
        key[idx] <= 1'b1;
        repeat (5) @(posedge clk_in);
    endtask

    task automatic inc_field(input int n);
        repeat (n) begin
            press_key(1, hold_cycles);
            model_inc();
        end
    endtask

    task automatic move_cursor();
        int last;
        last = (cur_mode == 3'b001) ? 5 : 2;
        press_key(0, hold_cycles);
        cur_field = (cur_field >= last) ? 0 : cur_field + 1;
    endtask

    task automatic goto_field(input int k);
        while (cur_field != k) begin
            move_cursor();
        end
    endtask

    task automatic set_mode(input logic [2:0] code);
        @(posedge clk_in);
        sw <= code;
        cur_mode = code;
        if ((code == 3'b011) && (cur_field > 2)) cur_field = 0;   // clamp on entry
        settle();
    endtask

    task automatic set_year_month(input int y, input int m);
        int target [0:3];
        target = '{(y / 1000) % 10, (y / 100) % 10, (y / 10) % 10, y % 10};
        for (int i = 0; i < 4; i++) begin
            goto_field(i);
            inc_field((target[i] - int'(yd[i]) + 10) % 10);
        end
        goto_field(4);
        inc_field((m - int'(mon_m) + 12) % 12);
    endtask

    task automatic apply_ticks(input int n);
        repeat (n) begin
            @(posedge clk_in);
            tick_1hz <= 1'b1;
            @(posedge clk_in);
            tick_1hz <= 1'b0;
        end
        settle();
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_digit(input string name, input digit_t got, input digit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_time(input hour_t h, input minsec_t m, input minsec_t s);
        check_digit("digit1", digit1, digit_t'(h / 10));
        check_digit("digit2", digit2, digit_t'(h % 10));
        check_digit("digit3", digit3, digit_t'(m / 10));
        check_digit("digit4", digit4, digit_t'(m % 10));
        check_digit("digit5", digit5, digit_t'(s / 10));
        check_digit("digit6", digit6, digit_t'(s % 10));
    endtask

    task automatic check_date(input year_t y, input month_t m, input day_t d);
        check_digit("digit1", digit1, digit_t'(y / 1000));
        check_digit("digit2", digit2, digit_t'((y / 100) % 10));
        check_digit("digit3", digit3, digit_t'((y / 10) % 10));
        check_digit("digit4", digit4, digit_t'(y % 10));
        check_digit("digit5", digit5, digit_t'(m / 10));
        check_digit("digit6", digit6, digit_t'(m % 10));
        check_digit("digit7", digit7, digit_t'(d / 10));
        check_digit("digit8", digit8, digit_t'(d % 10));
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int n;
        rst        = 1'b0;
        sw         = 3'b000;
        key        = 2'b11;
        tick_1hz   = 1'b0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 8'd75;
        do_reset();

        // short glitch ignored, long hold gives one increment
        set_mode(3'b011);
        press_key(1, 10);
        settle();
        check_time(0, 0, 0);
        press_key(1, 40);
        model_inc();
        settle();
        check_time(1, 0, 0);

        // random counts per time field
        for (int f = 0; f < 3; f++) begin
            inc_field(random_bits(5));
            settle();
            check_time(hour_m, min_m, sec_m);
            move_cursor();
        end
        inc_field(1);   // cursor is back on the hour
        settle();
        check_time(hour_m, min_m, sec_m);
        inc_field((23 - int'(hour_m) + 24) % 24);
        move_cursor();
        inc_field((59 - int'(min_m) + 60) % 60);
        move_cursor();
        inc_field((50 - int'(sec_m) + 60) % 60);
        settle();
        check_time(23, 59, 50);

        // time show, first tick loads, then counting across midnight
        set_mode(3'b010);
        check_time(0, 0, 0);
        apply_ticks(1);
        run_y  = 1;
        run_mo = 1;
        run_d  = 1;
        run_h  = hour_m;
        run_mi = min_m;
        run_s  = sec_m;
        check_time(run_h, run_mi, run_s);
        repeat (4) begin
            n = 4 + random_bits(4);
            apply_ticks(n);
            advance_clock(n, 1'b0, run_y, run_mo, run_d, run_h, run_mi, run_s);
            check_time(run_h, run_mi, run_s);
        end

        // day wrap in leap and non-leap february, month wrap
        do_reset();
        set_mode(3'b001);
        set_year_month(2024, 2);
        goto_field(5);
        inc_field(30);
        settle();
        check_date(2024, 2, 2);
        do_reset();
        set_mode(3'b001);
        set_year_month(2100, 2);
        goto_field(5);
        inc_field(30);
        settle();
        check_date(2100, 2, 3);
        goto_field(4);
        inc_field(13);
        settle();
        check_date(2100, 3, 3);

        // new year rollover through both show modes
        do_reset();
        set_mode(3'b001);
        set_year_month(2023, 12);
        goto_field(5);
        inc_field(30);
        set_mode(3'b011);
        goto_field(0);
        inc_field(23);
        move_cursor();
        inc_field(59);
        move_cursor();
        inc_field(50);
        settle();
        check_time(23, 59, 50);
        set_mode(3'b110);
        set_mode(3'b010);
        set_mode(3'b110);
        apply_ticks(11);
        run_y  = set_year();
        run_mo = mon_m;
        run_d  = day_m;
        run_h  = hour_m;
        run_mi = min_m;
        run_s  = sec_m;
        advance_clock(10, 1'b1, run_y, run_mo, run_d, run_h, run_mi, run_s);
        check_date(run_y, run_mo, run_d);
        set_mode(3'b010);
        check_time(run_h, run_mi, run_s);
        set_mode(3'b111);   // unused code freezes the display
        apply_ticks(3);
        check_time(run_h, run_mi, run_s);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/calendar_clock_top.sv */
`default_nettype none

module calendar_clock_top #(
    parameter int debounce_cycles = 25000
) (
    input  logic               clk_in,
    input  logic               rst,
    input  logic [2:0]         sw,
    input  logic [1:0]         key,        // active low
    input  logic               tick_1hz,
    output clock_pkg::digit_t  digit1,
    output clock_pkg::digit_t  digit2,
    output clock_pkg::digit_t  digit3,
    output clock_pkg::digit_t  digit4,
    output clock_pkg::digit_t  digit5,
    output clock_pkg::digit_t  digit6,
    output clock_pkg::digit_t  digit7,
    output clock_pkg::digit_t  digit8
);

    import clock_pkg::*;

    logic    move_press;
    logic    inc_press;
    logic    time_run;
    logic    date_run;
    mode_t   mode;
    year_t   year_set, year;
    month_t  mon_set, mon;
    day_t    day_set, day;
    hour_t   hour_set, hour;
    minsec_t min_set, min;
    minsec_t sec_set, sec;

    ////////////////////////////////////////////////////////////
    // keys
    ////////////////////////////////////////////////////////////

    key_debounce #(.debounce_cycles(debounce_cycles)) move_deb (
        .clk_in(clk_in), .rst(rst), .key_n(key[0]), .press(move_press)
    );

    key_debounce #(.debounce_cycles(debounce_cycles)) inc_deb (
        .clk_in(clk_in), .rst(rst), .key_n(key[1]), .press(inc_press)
    );

    ////////////////////////////////////////////////////////////
    // edit, count, display
    ////////////////////////////////////////////////////////////

    setting_editor editor (
        .clk_in(clk_in), .rst(rst), .sw(sw),
        .move_press(move_press), .inc_press(inc_press), .mode(mode),
        .year_set(year_set), .mon_set(mon_set), .day_set(day_set),
        .hour_set(hour_set), .min_set(min_set), .sec_set(sec_set),
        .time_run(time_run), .date_run(date_run)
    );

    timekeeper keeper (
        .clk_in(clk_in), .rst(rst), .tick_1hz(tick_1hz),
        .time_run(time_run), .date_run(date_run),
        .year_set(year_set), .mon_set(mon_set), .day_set(day_set),
        .hour_set(hour_set), .min_set(min_set), .sec_set(sec_set),
        .year(year), .mon(mon), .day(day), .hour(hour), .min(min), .sec(sec)
    );

    digit_formatter formatter (
        .clk_in(clk_in), .rst(rst), .mode(mode),
        .year_set(year_set), .mon_set(mon_set), .day_set(day_set),
        .hour_set(hour_set), .min_set(min_set), .sec_set(sec_set),
        .year(year), .mon(mon), .day(day), .hour(hour), .min(min), .sec(sec),
        .digit1(digit1), .digit2(digit2), .digit3(digit3), .digit4(digit4),
        .digit5(digit5), .digit6(digit6), .digit7(digit7), .digit8(digit8)
    );

endmodule

`default_nettype wire

/* src/clock_pkg.sv */
`default_nettype none

package clock_pkg;

    ////////////////////////////////////////////////////////////
    // field types
    ////////////////////////////////////////////////////////////

    typedef logic [13:0] year_t;    // 1 .. 9999
    typedef logic [3:0]  month_t;   // 1 .. 12
    typedef logic [4:0]  day_t;     // 1 .. 31
    typedef logic [4:0]  hour_t;    // 0 .. 23
    typedef logic [5:0]  minsec_t;  // 0 .. 59
    typedef logic [3:0]  digit_t;   // one bcd display digit
    typedef logic [2:0]  cursor_t;  // edit field index

    // sw[2:0] codes, anything else reads as idle
    typedef enum logic [2:0] {
        mode_idle      = 3'b000,
        mode_date_set  = 3'b001,
        mode_time_show = 3'b010,
        mode_time_set  = 3'b011,
        mode_date_show = 3'b110
    } mode_t;

    ////////////////////////////////////////////////////////////
    // calendar helper
    ////////////////////////////////////////////////////////////

    function automatic day_t days_in_month(year_t y, month_t m);
        logic leap;
        leap = ((y % 14'd4 == 14'd0) && (y % 14'd100 != 14'd0)) || (y % 14'd400 == 14'd0);
        case (m)
            4'd2:                    return leap ? 5'd29 : 5'd28;
            4'd4, 4'd6, 4'd9, 4'd11: return 5'd30;
            default:                 return 5'd31;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/digit_formatter.sv */
`default_nettype none

module digit_formatter (
    input  logic                clk_in,
    input  logic                rst,
    input  clock_pkg::mode_t    mode,
    input  clock_pkg::year_t    year_set,
    input  clock_pkg::month_t   mon_set,
    input  clock_pkg::day_t     day_set,
    input  clock_pkg::hour_t    hour_set,
    input  clock_pkg::minsec_t  min_set,
    input  clock_pkg::minsec_t  sec_set,
    input  clock_pkg::year_t    year,
    input  clock_pkg::month_t   mon,
    input  clock_pkg::day_t     day,
    input  clock_pkg::hour_t    hour,
    input  clock_pkg::minsec_t  min,
    input  clock_pkg::minsec_t  sec,
    output clock_pkg::digit_t   digit1,
    output clock_pkg::digit_t   digit2,
    output clock_pkg::digit_t   digit3,
    output clock_pkg::digit_t   digit4,
    output clock_pkg::digit_t   digit5,
    output clock_pkg::digit_t   digit6,
    output clock_pkg::digit_t   digit7,
    output clock_pkg::digit_t   digit8
);

    import clock_pkg::*;

    logic    show_date;
    logic    use_set;   // edit modes show the set registers
    year_t   sel_year;
    month_t  sel_mon;
    day_t    sel_day;
    hour_t   sel_hour;
    minsec_t sel_min;
    minsec_t sel_sec;
    digit_t  nxt [1:8];

    // decimal digit of v at the given power of ten
    function automatic digit_t dec_digit(year_t v, year_t weight);
        return digit_t'((v / weight) % 14'd10);
    endfunction

    always_comb begin
        show_date = (mode == mode_date_set) || (mode == mode_date_show);
        use_set   = (mode == mode_date_set) || (mode == mode_time_set);
        sel_year  = use_set ? year_set : year;
        sel_mon   = use_set ? mon_set  : mon;
        sel_day   = use_set ? day_set  : day;
        sel_hour  = use_set ? hour_set : hour;
        sel_min   = use_set ? min_set  : min;
        sel_sec   = use_set ? sec_set  : sec;
        if (show_date) begin
            nxt[1] = dec_digit(sel_year, 14'd1000);
            nxt[2] = dec_digit(sel_year, 14'd100);
            nxt[3] = dec_digit(sel_year, 14'd10);
            nxt[4] = dec_digit(sel_year, 14'd1);
            nxt[5] = dec_digit(14'(sel_mon), 14'd10);
            nxt[6] = dec_digit(14'(sel_mon), 14'd1);
            nxt[7] = dec_digit(14'(sel_day), 14'd10);
            nxt[8] = dec_digit(14'(sel_day), 14'd1);
        end else begin
            nxt[1] = dec_digit(14'(sel_hour), 14'd10);
            nxt[2] = dec_digit(14'(sel_hour), 14'd1);
            nxt[3] = dec_digit(14'(sel_min), 14'd10);
            nxt[4] = dec_digit(14'(sel_min), 14'd1);
            nxt[5] = dec_digit(14'(sel_sec), 14'd10);
            nxt[6] = dec_digit(14'(sel_sec), 14'd1);
            nxt[7] = 4'd0;     // unused in time modes
            nxt[8] = 4'd0;
        end
    end

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            digit1 <= '0;
            digit2 <= '0;
            digit3 <= '0;
            digit4 <= '0;
            digit5 <= '0;
            digit6 <= '0;
            digit7 <= '0;
            digit8 <= '0;
        end else if (mode != mode_idle) begin   // idle freezes the display
            digit1 <= nxt[1];
            digit2 <= nxt[2];
            digit3 <= nxt[3];
            digit4 <= nxt[4];
            digit5 <= nxt[5];
            digit6 <= nxt[6];
            digit7 <= nxt[7];
            digit8 <= nxt[8];
        end
    end

endmodule

`default_nettype wire

/* src/key_debounce.sv */
`default_nettype none

module key_debounce #(
    parameter int debounce_cycles = 25000
) (
    input  logic clk_in,
    input  logic rst,
    input  logic key_n,
    output logic press
);

    localparam int cnt_w = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_cycles - 1);

    logic [cnt_w-1:0] cnt;    // low time of the key
    logic             full;   // press already reported
    logic             hit;

    assign hit = (cnt == cnt_last);

    // saturates at cnt_last while the key stays down
    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (key_n) begin
            cnt <= '0;            // released, start over
        end else if (!hit) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (key_n) begin
            full <= 1'b0;
        end else if (hit) begin
            full <= 1'b1;         // held until release
        end
    end

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            press <= 1'b0;
        end else begin
            press <= hit && !full && !key_n;
        end
    end

    press_single_cycle: assert property (@(posedge clk_in) disable iff (!rst)
        press |=> !press);

endmodule

`default_nettype wire

/* src/setting_editor.sv */
`default_nettype none

module setting_editor (
    input  logic                                 clk_in,
    input  logic                                 rst,
    input  logic [$bits(clock_pkg::mode_t)-1:0]  sw,
    input  logic                                 move_press,
    input  logic                                 inc_press,
    output clock_pkg::mode_t                     mode,
    output clock_pkg::year_t                     year_set,
    output clock_pkg::month_t                    mon_set,
    output clock_pkg::day_t                      day_set,
    output clock_pkg::hour_t                     hour_set,
    output clock_pkg::minsec_t                   min_set,
    output clock_pkg::minsec_t                   sec_set,
    output logic                                 time_run,
    output logic                                 date_run
);

    import clock_pkg::*;

    mode_t   mode_next;
    cursor_t cursor;
    cursor_t cursor_step;       // cursor after a move, before clamping
    cursor_t cursor_last;
    digit_t  y_thou, y_hund, y_tens, y_unit;
    year_t   year_sum;
    day_t    day_last;
    logic    move_only;
    logic    inc_only;
    logic    editing;

    function automatic digit_t next_digit(digit_t d);
        return (d == 4'd9) ? 4'd0 : d + 4'd1;
    endfunction

    ////////////////////////////////////////////////////////////
    // mode and cursor
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (sw)
            mode_date_set, mode_time_set, mode_time_show, mode_date_show:
                mode_next = mode_t'(sw);
            default:
                mode_next = mode_idle;  // 111, 101, 100 fall back here
        endcase
    end

    assign move_only = move_press && !inc_press;   // both at once is dropped
    assign inc_only  = inc_press && !move_press;
    assign editing   = (mode == mode_date_set) || (mode == mode_time_set);

    always_comb begin
        cursor_last = (mode == mode_date_set) ? 3'd5 : 3'd2;
        cursor_step = cursor;
        if (move_only && editing) begin
            cursor_step = (cursor >= cursor_last) ? 3'd0 : cursor + 3'd1;
        end
    end

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            mode   <= mode_idle;
            cursor <= '0;
        end else begin
            mode   <= mode_next;
            // time set has only three fields
            cursor <= ((mode_next == mode_time_set) && (cursor_step > 3'd2)) ? 3'd0
                                                                            : cursor_step;
        end
    end

    ////////////////////////////////////////////////////////////
    // set date
    ////////////////////////////////////////////////////////////

    assign year_sum = 14'd1000 * y_thou + 14'd100 * y_hund + 14'd10 * y_tens + 14'(y_unit);
    assign year_set = (year_sum == '0) ? 14'd1 : year_sum;   // 0000 reads as 0001
    assign day_last = days_in_month(year_set, mon_set);

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            y_thou  <= 4'd0;
            y_hund  <= 4'd0;
            y_tens  <= 4'd0;
            y_unit  <= 4'd1;
            mon_set <= 4'd1;
            day_set <= 5'd1;
        end else if (inc_only && (mode == mode_date_set)) begin
            case (cursor)
                3'd0: y_thou <= next_digit(y_thou);
                3'd1: y_hund <= next_digit(y_hund);
                3'd2: y_tens <= next_digit(y_tens);
                3'd3: y_unit <= next_digit(y_unit);
                3'd4: mon_set <= (mon_set == 4'd12) ? 4'd1 : mon_set + 4'd1;
                3'd5: day_set <= (day_set >= day_last) ? 5'd1 : day_set + 5'd1;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // set time
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            hour_set <= '0;
            min_set  <= '0;
            sec_set  <= '0;
        end else if (inc_only && (mode == mode_time_set)) begin
            case (cursor)
                3'd0: hour_set <= (hour_set == 5'd23) ? 5'd0 : hour_set + 5'd1;
                3'd1: min_set  <= (min_set == 6'd59) ? 6'd0 : min_set + 6'd1;
                3'd2: sec_set  <= (sec_set == 6'd59) ? 6'd0 : sec_set + 6'd1;
                default: ;
            endcase
        end
    end

    // run enables stay on once the show mode was seen
    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            time_run <= 1'b0;
            date_run <= 1'b0;
        end else begin
            if (mode == mode_time_show) time_run <= 1'b1;
            if (mode == mode_date_show) date_run <= 1'b1;
        end
    end

    cursor_in_range: assert property (@(posedge clk_in) disable iff (!rst)
        (cursor <= 3'd5) && ((mode != mode_time_set) || (cursor <= 3'd2)));

endmodule

`default_nettype wire

/* src/timekeeper.sv */
`default_nettype none

module timekeeper (
    input  logic                clk_in,
    input  logic                rst,
    input  logic                tick_1hz,
    input  logic                time_run,
    input  logic                date_run,
    input  clock_pkg::year_t    year_set,
    input  clock_pkg::month_t   mon_set,
    input  clock_pkg::day_t     day_set,
    input  clock_pkg::hour_t    hour_set,
    input  clock_pkg::minsec_t  min_set,
    input  clock_pkg::minsec_t  sec_set,
    output clock_pkg::year_t    year,
    output clock_pkg::month_t   mon,
    output clock_pkg::day_t     day,
    output clock_pkg::hour_t    hour,
    output clock_pkg::minsec_t  min,
    output clock_pkg::minsec_t  sec
);

    import clock_pkg::*;

    logic time_loaded;
    logic date_loaded;
    logic midnight;     // this tick rolls 23:59:59 over
    day_t day_last;

    assign midnight = tick_1hz && time_loaded &&
                      (hour == 5'd23) && (min == 6'd59) && (sec == 6'd59);
    assign day_last = days_in_month(year, mon);

    ////////////////////////////////////////////////////////////
    // time of day
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            time_loaded <= 1'b0;
            hour        <= '0;
            min         <= '0;
            sec         <= '0;
        end else if (tick_1hz) begin
            if (!time_loaded) begin
                if (time_run) begin       // first tick only copies
                    time_loaded <= 1'b1;
                    hour        <= hour_set;
                    min         <= min_set;
                    sec         <= sec_set;
                end
            end else if (sec != 6'd59) begin
                sec <= sec + 6'd1;
            end else begin
                sec <= '0;
                if (min != 6'd59) begin
                    min <= min + 6'd1;
                end else begin
                    min  <= '0;
                    hour <= (hour == 5'd23) ? 5'd0 : hour + 5'd1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // calendar
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            date_loaded <= 1'b0;
            year        <= 14'd1;
            mon         <= 4'd1;
            day         <= 5'd1;
        end else if (tick_1hz) begin
            if (!date_loaded) begin
                if (date_run) begin
                    date_loaded <= 1'b1;
                    year        <= year_set;
                    mon         <= mon_set;
                    day         <= day_set;
                end
            end else if (midnight) begin
                if (day >= day_last) begin
                    day <= 5'd1;
                    if (mon == 4'd12) begin
                        mon  <= 4'd1;
                        year <= (year == 14'd9999) ? 14'd1 : year + 14'd1;
                    end else begin
                        mon <= mon + 4'd1;
                    end
                end else begin
                    day <= day + 5'd1;
                end
            end
        end
    end

    fields_legal: assert property (@(posedge clk_in) disable iff (!rst)
        (hour <= 5'd23) && (min <= 6'd59) && (sec <= 6'd59) &&
        (mon >= 4'd1) && (mon <= 4'd12) && (day >= 5'd1) &&
        (year >= 14'd1) && (year <= 14'd9999));

endmodule

`default_nettype wire

/* tb.f */
src/clock_pkg.sv
src/key_debounce.sv
src/setting_editor.sv
src/timekeeper.sv
src/digit_formatter.sv
src/calendar_clock_top.sv
bench/tb_calendar_clock.sv
